// File: src/aes_pkg.sv
package aes_pkg;

    // One state byte and a full block, byte 0 in the top bits
    typedef logic [7:0] aes_byte_t;
    typedef aes_byte_t [0:15] aes_block_t;

    // Round index, wide enough for AES-256
    typedef logic [3:0] round_idx_t;

    localparam int AES_ROUNDS_DEFAULT = 10;

    // Low byte of the field polynomial x^8 + x^4 + x^3 + x + 1
    localparam aes_byte_t AES_POLY_REDUCE = 8'h1b;

    // What the datapath does with the state in this cycle
    typedef struct packed {
        logic load;
        logic do_round;
        logic last_round;
    } aes_round_op_t;

    // Multiply by x, folding the carry back in
    function automatic aes_byte_t gf_xtime(input aes_byte_t a);
        aes_byte_t shifted;
        shifted = {a[6:0], 1'b0};
        if (a[7])
        begin
            shifted = shifted ^ AES_POLY_REDUCE;
        end
        return shifted;
    endfunction

    // Shift-and-add multiply in GF(2^8)
    function automatic aes_byte_t gf_mul(input aes_byte_t a, input aes_byte_t b);
        aes_byte_t acc;
        aes_byte_t term;
        acc  = 8'h00;
        term = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
            begin
                acc = acc ^ term;
            end
            term = gf_xtime(term);
        end
        return acc;
    endfunction

endpackage

// File: src/aes_sbox.sv
module aes_sbox
    import aes_pkg::*;
(
    input  aes_byte_t in_byte,
    output aes_byte_t out_byte
);

    aes_byte_t x2;
    aes_byte_t x3;
    aes_byte_t x6;
    aes_byte_t x12;
    aes_byte_t x15;
    aes_byte_t x30;
    aes_byte_t x60;
    aes_byte_t x120;
    aes_byte_t x240;
    aes_byte_t x252;
    aes_byte_t inv;

    // Inverse as x^254, which also sends 0 to 0
    always_comb
    begin
        x2   = gf_mul(in_byte, in_byte);
        x3   = gf_mul(x2, in_byte);
        x6   = gf_mul(x3, x3);
        x12  = gf_mul(x6, x6);
        x15  = gf_mul(x12, x3);
        x30  = gf_mul(x15, x15);
        x60  = gf_mul(x30, x30);
        x120 = gf_mul(x60, x60);
        x240 = gf_mul(x120, x120);
        x252 = gf_mul(x240, x12);
        inv  = gf_mul(x252, x2);
    end

    // Affine map as the XOR of four left rotations plus 63
    assign out_byte = inv
                    ^ {inv[6:0], inv[7]}
                    ^ {inv[5:0], inv[7:6]}
                    ^ {inv[4:0], inv[7:5]}
                    ^ {inv[3:0], inv[7:4]}
                    ^ 8'h63;

endmodule

// File: src/aes_mix_columns.sv
module aes_mix_columns
    import aes_pkg::*;
(
    input  aes_block_t in_block,
    output aes_block_t out_block
);

    // Doubled bytes, shared by the x2 and x3 terms
    aes_block_t dbl;

    always_comb
    begin
        for (int i = 0; i < 16; i++)
        begin
            dbl[i] = gf_xtime(in_block[i]);
        end
    end

    // Column c holds bytes 4c to 4c+3, row 0 first
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            out_block[4*c]   = dbl[4*c] ^ (dbl[4*c+1] ^ in_block[4*c+1])
                             ^ in_block[4*c+2] ^ in_block[4*c+3];
            out_block[4*c+1] = in_block[4*c] ^ dbl[4*c+1]
                             ^ (dbl[4*c+2] ^ in_block[4*c+2]) ^ in_block[4*c+3];
            out_block[4*c+2] = in_block[4*c] ^ in_block[4*c+1]
                             ^ dbl[4*c+2] ^ (dbl[4*c+3] ^ in_block[4*c+3]);
            out_block[4*c+3] = (dbl[4*c] ^ in_block[4*c]) ^ in_block[4*c+1]
                             ^ in_block[4*c+2] ^ dbl[4*c+3];
        end
    end

endmodule

// File: src/aes_round_datapath.sv
module aes_round_datapath
    import aes_pkg::*;
(
    input  logic          clk,
    input  logic          reset_n,
    input  aes_round_op_t op,
    input  aes_block_t    plain_text,
    input  aes_block_t    round_key,
    output aes_block_t    state
);

    aes_block_t sub_block;
    aes_block_t shifted;
    aes_block_t mixed;
    aes_block_t round_out;

    // SubBytes, one S-box per state byte
    for (genvar i = 0; i < 16; i++)
    begin : g_sbox
        aes_sbox sbox_i (
            .in_byte  (state[i]),
            .out_byte (sub_block[i])
        );
    end

    // ShiftRows rotates row r left by r columns
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                shifted[4*c + r] = sub_block[4*((c + r) % 4) + r];
            end
        end
    end

    aes_mix_columns mix_columns_i (
        .in_block  (shifted),
        .out_block (mixed)
    );

    // Final round skips MixColumns
    assign round_out = (op.last_round ? shifted : mixed) ^ round_key;

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            state <= '0;
        end
        else if (op.load)
        begin
            state <= plain_text ^ round_key;
        end
        else if (op.do_round)
        begin
            state <= round_out;
        end
    end

    // Load and round steps belong to different controller states
    assert property (@(posedge clk) disable iff (!reset_n)
        !(op.load && op.do_round))
        else $error("load and do_round asserted together");

endmodule

// File: src/aes_round_ctrl.sv
module aes_round_ctrl
    import aes_pkg::*;
#(
    parameter int NUM_ROUNDS = AES_ROUNDS_DEFAULT
)
(
    input  logic          clk,
    input  logic          reset_n,
    input  logic          start,
    output aes_round_op_t op,
    output round_idx_t    round_num,
    output logic          valid
);

    typedef enum logic [1:0] {
        IDLE,
        ROUNDS,
        FINAL,
        DONE
    } ctrl_state_t;

    localparam round_idx_t LAST_FULL = round_idx_t'(NUM_ROUNDS - 1);

    ctrl_state_t st;
    round_idx_t  count;

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            st    <= IDLE;
            count <= '0;
        end
        else
        begin
            case (st)
                IDLE:
                begin
                    if (start)
                    begin
                        st    <= ROUNDS;
                        count <= round_idx_t'(1);
                    end
                end
                ROUNDS:
                begin
                    count <= count + round_idx_t'(1);
                    if (count == LAST_FULL)
                    begin
                        st <= FINAL;
                    end
                end
                FINAL:
                begin
                    st    <= DONE;
                    count <= '0;
                end
                default:
                begin
                    // Start here is dropped, the next one is taken in IDLE
                    st    <= IDLE;
                    count <= '0;
                end
            endcase
        end
    end

    // Load has to act on the edge that samples start
    assign op.load       = (st == IDLE) && start;
    assign op.do_round   = (st == ROUNDS) || (st == FINAL);
    assign op.last_round = (st == FINAL);

    assign round_num = count;
    assign valid     = (st == DONE);

    // Key index stays inside the schedule the core was built for
    assert property (@(posedge clk) disable iff (!reset_n)
        round_num <= round_idx_t'(NUM_ROUNDS))
        else $error("round_num beyond NUM_ROUNDS");

    assert property (@(posedge clk) disable iff (!reset_n)
        valid |=> !valid)
        else $error("valid held for two cycles");

endmodule

// File: src/aes_cipher_core.sv
module aes_cipher_core
    import aes_pkg::*;
#(
    parameter int NUM_ROUNDS = AES_ROUNDS_DEFAULT
)
(
    input  logic       clk,
    input  logic       reset_n,
    input  logic       start,
    input  aes_block_t plain_text,
    input  aes_block_t round_key,
    output round_idx_t round_num,
    output logic       valid,
    output aes_block_t cipher_text
);

    aes_round_op_t op;

    // Sequencing and the key index
    aes_round_ctrl #(
        .NUM_ROUNDS (NUM_ROUNDS)
    ) round_ctrl_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .start     (start),
        .op        (op),
        .round_num (round_num),
        .valid     (valid)
    );

    // State register doubles as the ciphertext
    aes_round_datapath round_datapath_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .op         (op),
        .plain_text (plain_text),
        .round_key  (round_key),
        .state      (cipher_text)
    );

endmodule

// File: test/tb_aes_cipher_core.sv
module tb_aes_cipher_core
    import aes_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ROUNDS   = AES_ROUNDS_DEFAULT;
    localparam int LATENCY      = NUM_ROUNDS + 1;
    localparam int WAIT_LIMIT   = 4 * NUM_ROUNDS;
    localparam int RANDOM_COUNT = 50;
    localparam int BUSY_COUNT   = 10;

    logic       clk;
    logic       reset_n;
    logic       start;
    aes_block_t plain_text;
    aes_block_t round_key = '0;
    round_idx_t round_num;
    logic       valid;
    aes_block_t cipher_text;

    // Reference model tables
    aes_byte_t  sbox_tab [0:255];
    aes_block_t rk [0:15];

    int errors;
    int blocks;
    bit aborted;

    aes_cipher_core #(
        .NUM_ROUNDS (NUM_ROUNDS)
    ) aes_cipher_core_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .start       (start),
        .plain_text  (plain_text),
        .round_key   (round_key),
        .round_num   (round_num),
        .valid       (valid),
        .cipher_text (cipher_text)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #50 clk = ~clk;
        end
    end

    // External key schedule, indexed by the core
    always @(negedge clk)
    begin
        round_key = rk[round_num];
    end

    function automatic aes_byte_t times2(input aes_byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // Walk powers of 3 and of its inverse together
    task automatic build_sbox();
        aes_byte_t p;
        aes_byte_t q;
        aes_byte_t x;
        p = 8'h01;
        q = 8'h01;
        do
        begin
            p = p ^ (p << 1) ^ (p[7] ? 8'h1b : 8'h00);
            q = q ^ (q << 1);
            q = q ^ (q << 2);
            q = q ^ (q << 4);
            q = q ^ (q[7] ? 8'h09 : 8'h00);
            x = q ^ {q[6:0], q[7]} ^ {q[5:0], q[7:6]}
                  ^ {q[4:0], q[7:5]} ^ {q[3:0], q[7:4]};
            sbox_tab[p] = x ^ 8'h63;
        end
        while (p != 8'h01);
        sbox_tab[0] = 8'h63;
    endtask

    // FIPS-197 key expansion for a 128-bit key
    task automatic expand_key(input aes_block_t key);
        logic [31:0]  w [0:4*NUM_ROUNDS+3];
        logic [31:0]  t;
        logic [127:0] kv;
        aes_byte_t    rcon;
        kv   = key;
        rcon = 8'h01;
        for (int i = 0; i < 4; i++)
        begin
            w[i] = kv[127-32*i -: 32];
        end
        for (int i = 4; i < 4 * (NUM_ROUNDS + 1); i++)
        begin
            t = w[i-1];
            if (i % 4 == 0)
            begin
                // RotWord folded into the SubWord byte order
                t = {sbox_tab[t[23:16]], sbox_tab[t[15:8]], sbox_tab[t[7:0]], sbox_tab[t[31:24]]};
                t[31:24] = t[31:24] ^ rcon;
                rcon = times2(rcon);
            end
            w[i] = w[i-4] ^ t;
        end
        for (int r = 0; r <= NUM_ROUNDS; r++)
        begin
            rk[r] = {w[4*r], w[4*r+1], w[4*r+2], w[4*r+3]};
        end
    endtask

    function automatic aes_block_t model_encrypt(input aes_block_t pt);
        aes_block_t s;
        aes_block_t t;
        s = pt ^ rk[0];
        for (int r = 1; r <= NUM_ROUNDS; r++)
        begin
            // Byte i sits in row i%4, so the shift adds 4*row to its index
            for (int i = 0; i < 16; i++)
            begin
                t[i] = sbox_tab[s[(i + 4 * (i % 4)) % 16]];
            end
            if (r < NUM_ROUNDS)
            begin
                s = t;
                for (int c = 0; c < 4; c++)
                begin
                    for (int k = 0; k < 4; k++)
                    begin
                        t[4*c+k] = times2(s[4*c+k]) ^ times2(s[4*c+(k+1)%4])
                                 ^ s[4*c+(k+1)%4] ^ s[4*c+(k+2)%4] ^ s[4*c+(k+3)%4];
                    end
                end
            end
            s = t ^ rk[r];
        end
        return s;
    endfunction

    function automatic aes_block_t rand_block();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    task automatic check_block(input string name, input aes_block_t expected,
                               input aes_block_t actual);
        if (actual !== expected)
        begin
            $display("ERR %s cipher_text expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_round(input string name, input round_idx_t expected,
                               input round_idx_t actual);
        if (actual !== expected)
        begin
            $display("ERR %s round_num expected %0d actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_idle(input string name);
        if (valid !== 1'b0)
        begin
            $display("%s: valid is high while the core should be idle", name);
            errors++;
        end
        check_round(name, '0, round_num);
    endtask

    // One block from start to valid, busy adds stray starts and plaintexts
    task automatic run_block(input string name, input aes_block_t key, input aes_block_t pt,
                             input bit busy);
        aes_block_t expected;
        int         cycles;
        bit         seen;
        expand_key(key);
        expected = model_encrypt(pt);
        @(negedge clk);
        check_idle(name);
        start      = 1'b1;
        plain_text = pt;
        cycles     = 0;
        seen       = 1'b0;
        while (!seen && cycles < WAIT_LIMIT)
        begin
            @(negedge clk);
            cycles++;
            start = busy ? 1'($urandom()) : 1'b0;
            if (busy)
            begin
                plain_text = rand_block();
            end
            if (valid)
            begin
                seen  = 1'b1;
                start = busy;
            end
            else if (cycles <= NUM_ROUNDS)
            begin
                check_round(name, round_idx_t'(cycles), round_num);
            end
        end
        if (!seen)
        begin
            $display("%s: no valid pulse within %0d cycles", name, WAIT_LIMIT);
            errors++;
            aborted = 1'b1;
            return;
        end
        if (cycles != LATENCY)
        begin
            $display("ERR %s latency expected %0d actual %0d", name, LATENCY, cycles);
            errors++;
        end
        check_block(name, expected, cipher_text);
        blocks++;
        if (busy)
        begin
            // Start in the valid cycle leaves the core idle
            @(negedge clk);
            start = 1'b0;
            check_idle(name);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("%-10s %s, %0d errors", name,
                 (errors == errors_before) ? "ok" : "mismatch", errors - errors_before);
    endtask

    initial
    begin
        int first_errors;
        start      = 1'b0;
        plain_text = '0;
        reset_n    = 1'b0;
        errors     = 0;
        blocks     = 0;
        aborted    = 1'b0;
        void'($urandom(32'h0f87_4a06));
        build_sbox();
        for (int r = 0; r < 16; r++)
        begin
            rk[r] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        first_errors = errors;
        run_block("fips197", 128'h000102030405060708090a0b0c0d0e0f,
                  128'h00112233445566778899aabbccddeeff, 1'b0);
        check_block("fips197", 128'h69c4e0d86a7b0430d8cdb78070b4c55a, cipher_text);
        report_test("fips197", first_errors);

        // Back to back, each start in the cycle after valid
        first_errors = errors;
        for (int n = 0; n < RANDOM_COUNT && !aborted; n++)
        begin
            run_block($sformatf("random_%0d", n), rand_block(), rand_block(), 1'b0);
        end
        report_test("random", first_errors);

        first_errors = errors;
        for (int n = 0; n < BUSY_COUNT && !aborted; n++)
        begin
            run_block($sformatf("busy_%0d", n), rand_block(), rand_block(), 1'b1);
        end
        report_test("busy", first_errors);

        $display("blocks %0d, errors %0d", blocks, errors);
        if (errors == 0 && !aborted)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
src/aes_pkg.sv
src/aes_sbox.sv
src/aes_mix_columns.sv
src/aes_round_datapath.sv
src/aes_round_ctrl.sv
src/aes_cipher_core.sv
test/tb_aes_cipher_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_aes_cipher_core
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

# Build, run, then decide from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qxF '>>> PASS' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
